//--- src/ecc_pkg.sv
// ECC definitions shared by the codec, register block and memory controller
// Hamming (7,4) codeword, syndrome, stored word layout and controller state
package ecc_pkg;

  // Number of entries in the codeword array
  localparam int DEPTH = 16;
  // Entry index width
  localparam int ADDR_W = $clog2(DEPTH);

  // Bit i holds code position i+1
  // Parity at positions 1, 2, 4 and data d0..d3 at positions 3, 5, 6, 7
  typedef logic [6:0] codeword_t;

  // XOR of the indices of all set positions, nonzero names the bad position
  typedef logic [2:0] syndrome_t;

  // One byte as two codewords, hi nibble on top
  typedef struct packed {
    codeword_t hi;
    codeword_t lo;
  } stored_word_t;

  // Configuration driven by the register block
  typedef struct packed {
    logic        correct_en;
    logic [13:0] inj_mask;
    logic        inj_armed;
  } ecc_cfg_t;

  // Status pulse from the controller
  // valid marks a data read, inj_used marks a write that consumed the mask
  typedef struct packed {
    logic      valid;
    syndrome_t syn_hi;
    syndrome_t syn_lo;
    logic      inj_used;
  } ecc_event_t;

  // Bus handshake states
  typedef enum logic {
    S_IDLE,
    S_ACK
  } ctrl_state_t;

endpackage

//--- src/wb_pkg.sv
// Wishbone classic slave types and the internal register access format
// Also holds the register map of the ECC block
package wb_pkg;

  localparam int ADR_W = 5;
  localparam int DAT_W = 8;
  // Register address width inside the register region
  localparam int REG_AW = 3;

  // Master to slave, held stable until ack
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [ADR_W-1:0] adr;
    logic [DAT_W-1:0] dat_w;
  } wb_req_t;

  // Slave to master, dat_r valid with ack
  typedef struct packed {
    logic             ack;
    logic [DAT_W-1:0] dat_r;
  } wb_rsp_t;

  // Single-cycle register access from the controller
  typedef struct packed {
    logic              valid;
    logic              we;
    logic [REG_AW-1:0] addr;
    logic [DAT_W-1:0]  wdata;
  } reg_access_t;

  // Addresses 5 to 7 are unmapped
  typedef enum logic [REG_AW-1:0] {
    REG_CTRL     = 3'd0,
    REG_INJ_LO   = 3'd1,
    REG_INJ_HI   = 3'd2,
    REG_ERR_CNT  = 3'd3,
    REG_LAST_SYN = 3'd4
  } reg_addr_t;

endpackage

//--- src/hamming_encoder.sv
// Hamming (7,4) encoder, one nibble into one codeword
module hamming_encoder
  import ecc_pkg::*;
(
  input  logic [3:0] nibble,
  output codeword_t  code
);

  logic p1;
  logic p2;
  logic p4;

  // Even parity over positions sharing each index bit
  // p1 covers 3,5,7 and p2 covers 3,6,7
  assign p1 = nibble[0] ^ nibble[1] ^ nibble[3];
  assign p2 = nibble[0] ^ nibble[2] ^ nibble[3];
  // p4 covers 5,6,7
  assign p4 = nibble[1] ^ nibble[2] ^ nibble[3];

  // Data at positions 3, 5, 6, 7
  assign code[0] = p1;
  assign code[1] = p2;
  assign code[2] = nibble[0];
  assign code[3] = p4;
  assign code[4] = nibble[1];
  assign code[5] = nibble[2];
  assign code[6] = nibble[3];

endmodule

//--- src/hamming_decoder.sv
// Hamming (7,4) decoder with optional single-bit correction
// Clock and reset only time the built-in code checks
module hamming_decoder
  import ecc_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  codeword_t  code,
  input  logic       correct_en,
  output logic [3:0] nibble,
  output syndrome_t  syndrome
);

  codeword_t fixed;

  // Syndrome bit k is the parity of all positions with index bit k set
  function automatic syndrome_t calc_syn(codeword_t c);
    syndrome_t s;
    s[0] = c[0] ^ c[2] ^ c[4] ^ c[6];
    s[1] = c[1] ^ c[2] ^ c[5] ^ c[6];
    s[2] = c[3] ^ c[4] ^ c[5] ^ c[6];
    return s;
  endfunction

  assign syndrome = calc_syn(code);

  // Position s sits at bit s-1
  always_comb begin
    fixed = code;
    if (correct_en && syndrome != '0) begin
      fixed[syndrome - 3'd1] = ~code[syndrome - 3'd1];
    end
  end

  // Data positions 7, 6, 5, 3
  assign nibble = {fixed[6], fixed[5], fixed[4], fixed[2]};

  // Clean codeword passes its data positions straight through
  a_clean_passthru: assert property (
    @(posedge clk) disable iff (rst)
    (syndrome == '0) |-> (nibble == {code[6], code[5], code[4], code[2]})
  ) else $error("decoder altered data of a clean codeword");

  // Corrected word is a valid codeword again, so it re-encodes to itself
  // (holds because every nonzero syndrome names one of the 7 positions)
  a_fixed_valid: assert property (
    @(posedge clk) disable iff (rst)
    correct_en |-> (calc_syn(fixed) == '0)
  ) else $error("corrected codeword still has a nonzero syndrome");

endmodule

//--- src/ecc_csr.sv
// ECC register block with correction enable, one-shot injection mask,
// saturating error counter and last syndrome pair
module ecc_csr
  import ecc_pkg::*, wb_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  reg_access_t access,
  output logic [7:0]  rdata,
  output ecc_cfg_t    cfg,
  input  ecc_event_t  evt
);

  logic        correct_en;
  logic [13:0] inj_mask;
  logic        inj_armed;
  logic [7:0]  err_cnt;
  syndrome_t   last_syn_hi;
  syndrome_t   last_syn_lo;
  logic        wr;
  logic        cnt_clr;
  logic [1:0]  n_err;
  logic [8:0]  cnt_sum;

  assign wr      = access.valid && access.we;
  assign cnt_clr = wr && (access.addr == REG_ERR_CNT);

  // Nonzero syndromes in this read, 0 to 2
  assign n_err   = 2'(evt.syn_hi != '0) + 2'(evt.syn_lo != '0);
  assign cnt_sum = {1'b0, err_cnt} + {7'b0, n_err};

  always_ff @(posedge clk) begin
    if (rst) begin
      correct_en  <= 1'b1;
      inj_mask    <= '0;
      inj_armed   <= 1'b0;
      err_cnt     <= '0;
      last_syn_hi <= '0;
      last_syn_lo <= '0;
    end else begin
      if (wr) begin
        case (reg_addr_t'(access.addr))
          REG_CTRL:   correct_en <= access.wdata[0];
          REG_INJ_LO: inj_mask[7:0] <= access.wdata;
          // Upper mask half arms the next data write
          REG_INJ_HI: begin
            inj_mask[13:8] <= access.wdata[5:0];
            inj_armed      <= 1'b1;
          end
          default: ;
        endcase
      end
      // Mask consumed by a data write
      if (evt.inj_used) begin
        inj_armed <= 1'b0;
      end
      if (cnt_clr) begin
        err_cnt <= '0;
      end else if (evt.valid) begin
        // Saturate at 255
        err_cnt <= cnt_sum[8] ? 8'hFF : cnt_sum[7:0];
      end
      if (evt.valid) begin
        last_syn_hi <= evt.syn_hi;
        last_syn_lo <= evt.syn_lo;
      end
    end
  end

  // Read mux, unmapped addresses read zero
  always_comb begin
    case (reg_addr_t'(access.addr))
      REG_CTRL:     rdata = {7'b0, correct_en};
      REG_INJ_LO:   rdata = inj_mask[7:0];
      REG_INJ_HI:   rdata = {2'b0, inj_mask[13:8]};
      REG_ERR_CNT:  rdata = err_cnt;
      REG_LAST_SYN: rdata = {1'b0, last_syn_hi, 1'b0, last_syn_lo};
      default:      rdata = '0;
    endcase
  end

  assign cfg = '{correct_en: correct_en, inj_mask: inj_mask, inj_armed: inj_armed};

  // Counter only moves up unless cleared, and sticks once saturated
  a_cnt_mono: assert property (
    @(posedge clk) disable iff (rst)
    !cnt_clr |=> (err_cnt >= $past(err_cnt))
  ) else $error("error counter decreased without a clear");

endmodule

//--- src/ecc_mem_ctrl.sv
// Wishbone classic slave for the ECC scratch memory
// Splits data and register regions, holds the codeword array
module ecc_mem_ctrl
  import ecc_pkg::*, wb_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  wb_req_t      req,
  output wb_rsp_t      rsp,
  input  stored_word_t enc_word,
  output stored_word_t rd_word,
  input  logic [7:0]   dec_nibbles,
  input  syndrome_t    dec_syn_hi,
  input  syndrome_t    dec_syn_lo,
  output reg_access_t  reg_access,
  input  logic [7:0]   reg_rdata,
  input  ecc_cfg_t     cfg,
  output ecc_event_t   evt
);

  ctrl_state_t       state;
  ctrl_state_t       state_nxt;
  stored_word_t      mem [DEPTH];
  logic [ADDR_W-1:0] idx;
  logic              accept;
  logic              is_reg;
  logic              data_wr;
  logic              data_rd;
  logic [7:0]        dat_q;
  logic              rd_evt_q;
  syndrome_t         syn_hi_q;
  syndrome_t         syn_lo_q;

  // adr[4] selects the register region
  assign is_reg  = req.adr[4];
  assign idx     = req.adr[ADDR_W-1:0];
  // Request taken in the first cycle seen in idle
  assign accept  = (state == S_IDLE) && req.cyc && req.stb;
  assign data_wr = accept && req.we && !is_reg;
  assign data_rd = accept && !req.we && !is_reg;

  // Always back to idle after ack, so held stb is served every other cycle
  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE:  if (accept) state_nxt = S_ACK;
      S_ACK:   state_nxt = S_IDLE;
      default: state_nxt = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= S_IDLE;
      rd_evt_q <= 1'b0;
    end else begin
      state    <= state_nxt;
      rd_evt_q <= data_rd;
    end
  end

  // Array write, injection mask applied when armed
  always_ff @(posedge clk) begin
    if (data_wr) begin
      mem[idx] <= enc_word ^ (cfg.inj_armed ? cfg.inj_mask : 14'b0);
    end
  end

  // Decoders see the addressed entry directly
  assign rd_word = mem[idx];

  // Read data and syndromes captured at the accepting edge
  always_ff @(posedge clk) begin
    if (accept) begin
      dat_q    <= is_reg ? reg_rdata : dec_nibbles;
      syn_hi_q <= dec_syn_hi;
      syn_lo_q <= dec_syn_lo;
    end
  end

  // One pulse to the register block in the request's first cycle
  assign reg_access = '{valid: accept && is_reg, we: req.we,
                        addr: req.adr[2:0], wdata: req.dat_w};

  // Read event is registered, injection use is flagged in the write cycle
  assign evt = '{valid: rd_evt_q, syn_hi: syn_hi_q, syn_lo: syn_lo_q,
                 inj_used: data_wr && cfg.inj_armed};

  assign rsp = '{ack: (state == S_ACK), dat_r: dat_q};

  // Ack only while the master still holds the request on the bus
  a_ack_req: assert property (
    @(posedge clk) disable iff (rst)
    rsp.ack |-> (req.cyc && req.stb)
  ) else $error("ack high without an active request");

  // Single-cycle ack
  a_ack_pulse: assert property (
    @(posedge clk) disable iff (rst)
    rsp.ack |=> !rsp.ack
  ) else $error("ack held for two cycles");

endmodule

//--- src/ecc_mem_top.sv
// ECC scratch memory top, Wishbone slave with Hamming (7,4) protected nibbles
module ecc_mem_top
  import ecc_pkg::*, wb_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp
);

  stored_word_t enc_word;
  stored_word_t rd_word;
  logic [7:0]   dec_nibbles;
  syndrome_t    syn_hi;
  syndrome_t    syn_lo;
  reg_access_t  reg_acc;
  logic [7:0]   reg_rdata;
  ecc_cfg_t     cfg;
  ecc_event_t   evt;

  ecc_mem_ctrl ctrl_i (
    .clk        (clk),
    .rst        (rst),
    .req        (wb_req),
    .rsp        (wb_rsp),
    .enc_word   (enc_word),
    .rd_word    (rd_word),
    .dec_nibbles(dec_nibbles),
    .dec_syn_hi (syn_hi),
    .dec_syn_lo (syn_lo),
    .reg_access (reg_acc),
    .reg_rdata  (reg_rdata),
    .cfg        (cfg),
    .evt        (evt)
  );

  ecc_csr csr_i (
    .clk   (clk),
    .rst   (rst),
    .access(reg_acc),
    .rdata (reg_rdata),
    .cfg   (cfg),
    .evt   (evt)
  );

  // Write path, one encoder per nibble
  hamming_encoder enc_hi_i (.nibble(wb_req.dat_w[7:4]), .code(enc_word.hi));
  hamming_encoder enc_lo_i (.nibble(wb_req.dat_w[3:0]), .code(enc_word.lo));

  // Read path on the addressed entry
  hamming_decoder dec_hi_i (
    .clk(clk), .rst(rst), .code(rd_word.hi), .correct_en(cfg.correct_en),
    .nibble(dec_nibbles[7:4]), .syndrome(syn_hi)
  );
  hamming_decoder dec_lo_i (
    .clk(clk), .rst(rst), .code(rd_word.lo), .correct_en(cfg.correct_en),
    .nibble(dec_nibbles[3:0]), .syndrome(syn_lo)
  );

endmodule

//--- verif/ecc_mem_checker.sv
// Bus monitor and reference model for the ECC scratch memory
// Compares read data on every ack and flags handshake errors
module ecc_mem_checker
  import ecc_pkg::*, wb_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  wb_req_t wb_req,
  input  wb_rsp_t wb_rsp,
  output int      mismatches,
  output int      proto_errs
);

  // Model array holds codewords as stored, injection included
  stored_word_t model_mem [DEPTH];
  logic         m_correct_en;
  logic [13:0]  m_inj_mask;
  logic         m_inj_armed;
  logic [7:0]   m_err_cnt;
  syndrome_t    m_syn_hi;
  syndrome_t    m_syn_lo;
  int           wait_cycles;
  logic         ack_q;

  // XOR of the indices of all positions holding a 1
  function automatic syndrome_t syndrome_of(codeword_t c);
    syndrome_t s;
    s = 3'd0;
    for (int i = 0; i < 7; i++) begin
      if (c[3'(i)]) s = s ^ 3'(i + 1);
    end
    return s;
  endfunction

  // Data at positions 3, 5, 6, 7, then parity cancels the data syndrome
  function automatic codeword_t encode_nibble(logic [3:0] n);
    codeword_t w;
    syndrome_t s;
    w = {n[3], n[2], n[1], 1'b0, n[0], 2'b00};
    s = syndrome_of(w);
    w[0] = s[0];
    w[1] = s[1];
    w[3] = s[2];
    return w;
  endfunction

  // Nonzero syndrome s names position s, which is bit s-1
  function automatic logic [3:0] decode_nibble(codeword_t c, logic fix);
    codeword_t w;
    syndrome_t s;
    w = c;
    s = syndrome_of(c);
    if (fix && s != 3'd0) w[s - 3'd1] = ~w[s - 3'd1];
    return {w[6], w[5], w[4], w[2]};
  endfunction

  // Shadow register file read, unmapped addresses give zero
  function automatic logic [7:0] expected_reg(logic [2:0] a);
    case (reg_addr_t'(a))
      REG_CTRL:     return {7'b0, m_correct_en};
      REG_INJ_LO:   return m_inj_mask[7:0];
      REG_INJ_HI:   return {2'b0, m_inj_mask[13:8]};
      REG_ERR_CNT:  return m_err_cnt;
      REG_LAST_SYN: return {1'b0, m_syn_hi, 1'b0, m_syn_lo};
      default:      return 8'h00;
    endcase
  endfunction

  always @(posedge clk) begin
    stored_word_t w;
    logic [7:0]   expect_dat;
    logic         is_rd;
    int           n;
    if (rst) begin
      m_correct_en = 1'b1;
      m_inj_mask   = 14'h0;
      m_inj_armed  = 1'b0;
      m_err_cnt    = 8'h00;
      m_syn_hi     = 3'd0;
      m_syn_lo     = 3'd0;
      wait_cycles  = 0;
      ack_q        = 1'b0;
      mismatches   = 0;
      proto_errs   = 0;
    end else begin
      // Handshake rules
      if (wb_rsp.ack && !(wb_req.cyc && wb_req.stb)) begin
        $display("Protocol error at time %0t: ack without an active request", $time);
        proto_errs++;
      end
      if (wb_rsp.ack && ack_q) begin
        $display("Protocol error at time %0t: ack held high for two cycles", $time);
        proto_errs++;
      end
      ack_q = wb_rsp.ack;
      if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) wait_cycles++;
      else wait_cycles = 0;
      if (wait_cycles == 4) begin
        $display("Protocol error at time %0t: no acknowledge within 4 cycles", $time);
        proto_errs++;
      end
      // Model update at ack, request still held
      is_rd      = 1'b0;
      expect_dat = 8'h00;
      if (wb_rsp.ack && !wb_req.adr[4] && wb_req.we) begin
        w = {encode_nibble(wb_req.dat_w[7:4]), encode_nibble(wb_req.dat_w[3:0])};
        if (m_inj_armed) w = w ^ m_inj_mask;
        model_mem[wb_req.adr[3:0]] = w;
        m_inj_armed = 1'b0;
      end else if (wb_rsp.ack && !wb_req.adr[4]) begin
        w = model_mem[wb_req.adr[3:0]];
        is_rd = 1'b1;
        expect_dat = {decode_nibble(w.hi, m_correct_en), decode_nibble(w.lo, m_correct_en)};
        m_syn_hi = syndrome_of(w.hi);
        m_syn_lo = syndrome_of(w.lo);
        n = int'(m_syn_hi != 3'd0) + int'(m_syn_lo != 3'd0);
        // Saturating count of nibbles with a nonzero syndrome
        m_err_cnt = (int'(m_err_cnt) + n > 255) ? 8'hFF : 8'(int'(m_err_cnt) + n);
      end else if (wb_rsp.ack && wb_req.we) begin
        case (reg_addr_t'(wb_req.adr[2:0]))
          REG_CTRL:    m_correct_en = wb_req.dat_w[0];
          REG_INJ_LO:  m_inj_mask[7:0] = wb_req.dat_w;
          REG_INJ_HI: begin
            m_inj_mask[13:8] = wb_req.dat_w[5:0];
            m_inj_armed      = 1'b1;
          end
          REG_ERR_CNT: m_err_cnt = 8'h00;
          default: ;
        endcase
      end else if (wb_rsp.ack) begin
        is_rd      = 1'b1;
        expect_dat = expected_reg(wb_req.adr[2:0]);
      end
      if (is_rd && wb_rsp.dat_r !== expect_dat) begin
        $display("FAIL at time %0t: read of adr %h returned %h, expected %h",
                 $time, wb_req.adr, wb_rsp.dat_r, expect_dat);
        mismatches++;
      end
    end
  end

endmodule

//--- verif/ecc_mem_tb.sv
// Testbench for the ECC scratch memory, drives Wishbone requests
// and leaves the comparing to the bus checker
module ecc_mem_tb
  import wb_pkg::*;
();

  // About 400 transactions at 20 cycles each, plus margin
  localparam int N_TXN      = 400;
  localparam int MAX_CYCLES = 20 * N_TXN + 100;

  logic    clk;
  logic    rst;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  int      cycles = 0;
  int      mismatches;
  int      proto_errs;

  ecc_mem_top dut_i (.clk(clk), .rst(rst), .wb_req(wb_req), .wb_rsp(wb_rsp));

  ecc_mem_checker checker_i (
    .clk       (clk),
    .rst       (rst),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .mismatches(mismatches),
    .proto_errs(proto_errs)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout: test did not finish within %0d cycles", MAX_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [4:0] reg_adr(logic [2:0] r);
    return {2'b10, r};
  endfunction

  // Request held until ack, released one cycle later
  task automatic bus_cycle(input logic we, input logic [4:0] adr, input logic [7:0] dat);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: dat};
    do begin
      @(posedge clk);
      #1;
    end while (!wb_rsp.ack);
    @(posedge clk);
    #1;
  endtask

  task automatic wb_write(input logic [4:0] adr, input logic [7:0] dat);
    bus_cycle(1'b1, adr, dat);
  endtask

  task automatic wb_read(input logic [4:0] adr);
    bus_cycle(1'b0, adr, 8'h00);
  endtask

  task automatic bus_idle();
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    @(posedge clk);
    #1;
  endtask

  // Low half first, the upper half arms the next data write
  task automatic arm_injection(input logic [13:0] mask);
    wb_write(reg_adr(REG_INJ_LO), mask[7:0]);
    wb_write(reg_adr(REG_INJ_HI), {2'b00, mask[13:8]});
  endtask

  initial begin
    int b1;
    int b2;
    void'($urandom(67573));
    wb_req = '0;
    rst    = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    // Clean bytes in every entry
    for (int i = 0; i < 16; i++) wb_write(5'(i), 8'($urandom));
    for (int i = 0; i < 16; i++) wb_read(5'(i));
    wb_read(reg_adr(REG_ERR_CNT));
    // Single-bit injection over all 14 stored bits
    for (int b = 0; b < 14; b++) begin
      arm_injection(14'(1) << b);
      wb_write(5'(b), 8'($urandom));
      wb_read(5'(b));
      wb_read(reg_adr(REG_ERR_CNT));
      wb_read(reg_adr(REG_LAST_SYN));
    end
    wb_read(reg_adr(REG_INJ_LO));
    wb_read(reg_adr(REG_INJ_HI));
    // One bit in each codeword, second write must stay clean
    for (int k = 0; k < 8; k++) begin
      b1 = int'($urandom % 7);
      b2 = 7 + int'($urandom % 7);
      arm_injection((14'(1) << b1) | (14'(1) << b2));
      wb_write(5'(k), 8'($urandom));
      wb_write(5'(k + 8), 8'($urandom));
      wb_read(5'(k));
      wb_read(5'(k + 8));
      wb_read(reg_adr(REG_ERR_CNT));
      bus_idle();
    end
    // Correction off, raw data positions come back
    wb_write(reg_adr(REG_CTRL), 8'h00);
    for (int k = 0; k < 6; k++) begin
      arm_injection(14'(1) << int'($urandom % 14));
      wb_write(5'(k), 8'($urandom));
      wb_read(5'(k));
      wb_read(reg_adr(REG_ERR_CNT));
    end
    wb_read(reg_adr(REG_CTRL));
    wb_write(reg_adr(REG_CTRL), 8'h01);
    // Counter clear, then saturation with stb held
    wb_write(reg_adr(REG_ERR_CNT), 8'h00);
    wb_read(reg_adr(REG_ERR_CNT));
    arm_injection(14'h0081);
    wb_write(5'd15, 8'h5A);
    repeat (132) wb_read(5'd15);
    wb_read(reg_adr(REG_ERR_CNT));
    for (int r = 5; r < 8; r++) wb_read(reg_adr(3'(r)));
    bus_idle();
    repeat (4) @(posedge clk);
    $display("Checks done: mismatches=%0d protocol_errors=%0d", mismatches, proto_errs);
    if (mismatches == 0 && proto_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- sources.f
src/ecc_pkg.sv
src/wb_pkg.sv
src/hamming_encoder.sv
src/hamming_decoder.sv
src/ecc_csr.sv
src/ecc_mem_ctrl.sv
src/ecc_mem_top.sv
verif/ecc_mem_checker.sv
verif/ecc_mem_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the ECC memory testbench with Verilator
verilator --binary --timing --assert -f sources.f --top-module ecc_mem_tb > build.log 2>&1 \
  && ./obj_dir/Vecc_mem_tb > sim.log 2>&1 \
  && grep -q "RESULT: PASS" sim.log \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
echo "Simulation passed"
